// File: hw/hist_accum_pkg.sv
`default_nettype none

package hist_accum_pkg;

    localparam int HIST_WORD_WIDTH = 32;   // one incoming bin count
    localparam int MAX_ADDR_WIDTH  = 12;   // up to 4096 bins

    // plain vectors, named by what they carry
    typedef logic [HIST_WORD_WIDTH-1:0]   hist_word_t;
    typedef logic [2*HIST_WORD_WIDTH-1:0] bin_count_t;   // running total per bin
    typedef logic [MAX_ADDR_WIDTH-1:0]    bin_addr_t;
    typedef logic [MAX_ADDR_WIDTH:0]      bin_index_t;   // weight n = addr + 1

    // sum of x, one index width of headroom
    typedef logic [2*HIST_WORD_WIDTH+MAX_ADDR_WIDTH:0] count_sum_t;
    // sum of n*x, two index widths of headroom
    typedef logic [2*HIST_WORD_WIDTH+2*MAX_ADDR_WIDTH+1:0] weighted_sum_t;

    // input beat, one count per cycle
    typedef struct packed {
        logic       valid;
        hist_word_t count;
    } bin_in_t;

    // updated total going out, also used inside the block
    typedef struct packed {
        logic       valid;
        logic       last;    // final bin of the frame
        bin_addr_t  addr;
        bin_count_t count;
    } bin_beat_t;

    typedef struct packed {
        logic zero_read;    // treat stored totals as zero
        logic zero_write;   // write zero back instead of the sum
    } store_ctrl_t;

endpackage

`default_nettype wire

// File: hw/seq_divider.sv
`default_nettype none

module seq_divider (
    input  wire                               clk,
    input  wire                               hist_reset,
    input  wire                               start_i,
    input  wire hist_accum_pkg::weighted_sum_t dividend_i,
    input  wire hist_accum_pkg::count_sum_t    divisor_i,
    output hist_accum_pkg::weighted_sum_t      quotient_o,
    output hist_accum_pkg::count_sum_t         remainder_o,
    output logic                               done_o
);
    import hist_accum_pkg::*;

    localparam int QW = $bits(weighted_sum_t);   // one cycle per quotient bit
    localparam int RW = $bits(count_sum_t);
    localparam int CW = $clog2(QW + 1);

    weighted_sum_t quo_q;     // dividend shifts out, quotient shifts in
    count_sum_t    rem_q;
    count_sum_t    dsr_q;
    logic [CW-1:0] bits_q;    // quotient bits still to produce
    logic          busy_q;
    logic [RW:0]   trial;     // partial remainder with next dividend bit
    logic [RW:0]   diff;
    logic          fits;

    assign trial = {rem_q, quo_q[QW-1]};
    assign diff  = trial - {1'b0, dsr_q};
    assign fits  = trial >= {1'b0, dsr_q};

    always_ff @(posedge clk) begin
        if (start_i && !busy_q) begin
            quo_q <= dividend_i;
            rem_q <= '0;
            dsr_q <= divisor_i;
        end else if (busy_q) begin
            // restoring step, keep the trial when the divisor does not fit
            rem_q <= fits ? diff[RW-1:0] : trial[RW-1:0];
            quo_q <= {quo_q[QW-2:0], fits};
        end

        if (hist_reset) begin
            busy_q <= 1'b0;
            bits_q <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i && !busy_q) begin    // start ignored while busy
                busy_q <= 1'b1;
                bits_q <= CW'(QW);
            end else if (busy_q) begin
                bits_q <= bits_q - 1'b1;
                if (bits_q == CW'(1)) begin
                    busy_q <= 1'b0;
                    done_o <= 1'b1;          // QW cycles after start taken
                end
            end
        end
    end

    assign quotient_o  = quo_q;
    assign remainder_o = rem_q;

endmodule

`default_nettype wire

// File: hw/bin_store.sv
`default_nettype none

module bin_store #(
    parameter int BIN_DEPTH = 4096
) (
    input  wire                             clk,
    input  wire                             rd_en_i,
    input  wire hist_accum_pkg::bin_addr_t  rd_addr_i,
    input  wire                             wr_en_i,
    input  wire hist_accum_pkg::bin_addr_t  wr_addr_i,
    input  wire hist_accum_pkg::bin_count_t wr_data_i,
    output hist_accum_pkg::bin_count_t      rd_data_o
);
    import hist_accum_pkg::*;

    localparam int AW = (BIN_DEPTH > 1) ? $clog2(BIN_DEPTH) : 1;

    bin_count_t mem [BIN_DEPTH];   // block ram
    bin_count_t ram_q;             // first read stage

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i[AW-1:0]] <= wr_data_i;
        end
        if (rd_en_i) begin
            ram_q <= mem[rd_addr_i[AW-1:0]];
        end
        rd_data_o <= ram_q;   // output register, second cycle
    end

endmodule

`default_nettype wire

// File: hw/hist_ctrl.sv
`default_nettype none

module hist_ctrl #(
    parameter int BIN_DEPTH = 4096
) (
    input  wire                            clk,
    input  wire                            hist_reset,
    input  wire                            clear_i,
    input  wire hist_accum_pkg::bin_beat_t beat_i,
    output hist_accum_pkg::store_ctrl_t    ctrl_o
);
    import hist_accum_pkg::*;

    localparam bin_addr_t LAST_ADDR = bin_addr_t'(BIN_DEPTH - 1);

    logic clear_pend_q;    // clear seen, waiting for the next frame
    logic in_frame_q;
    logic store_empty_q;   // nothing valid written back since reset
    logic zero_wr_q;
    logic frame_start;
    logic frame_end;

    assign frame_start = beat_i.valid && !in_frame_q;
    // last beat of a complete frame
    assign frame_end = beat_i.valid && beat_i.last && (beat_i.addr == LAST_ADDR);

    // first beat of a frame picks up the pending clear straight away
    assign ctrl_o = '{zero_read:  store_empty_q,
                      zero_write: frame_start ? clear_pend_q : zero_wr_q};

    always_ff @(posedge clk) begin
        if (hist_reset) begin
            clear_pend_q  <= 1'b0;
            in_frame_q    <= 1'b0;
            store_empty_q <= 1'b1;   // memory content unknown after reset
            zero_wr_q     <= 1'b0;
        end else begin
            if (frame_start) begin
                in_frame_q   <= 1'b1;
                zero_wr_q    <= clear_pend_q;   // held for the whole frame
                clear_pend_q <= clear_i;        // strobe on first beat waits
            end else if (frame_end) begin
                in_frame_q    <= 1'b0;
                store_empty_q <= 1'b0;          // totals now in the store
                zero_wr_q     <= clear_pend_q | clear_i;
                clear_pend_q  <= clear_pend_q | clear_i;
            end else begin
                clear_pend_q <= clear_pend_q | clear_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/bin_updater.sv
`default_nettype none

module bin_updater #(
    parameter int BIN_DEPTH = 4096
) (
    input  wire                              clk,
    input  wire                              hist_reset,
    input  wire hist_accum_pkg::bin_in_t     bin_i,
    input  wire hist_accum_pkg::store_ctrl_t ctrl_i,
    output hist_accum_pkg::bin_beat_t        beat_o
);
    import hist_accum_pkg::*;

    localparam bin_addr_t LAST_ADDR = bin_addr_t'(BIN_DEPTH - 1);

    logic [2:0] vld_q;          // input valid per stage
    hist_word_t cnt_q [3];      // count delayed to meet the read data
    bin_addr_t  rd_addr_q;
    bin_addr_t  out_addr_q;     // address of the next outgoing beat
    bin_count_t rd_data;
    bin_count_t stored;
    bin_count_t sum;
    bin_beat_t  beat_q;
    logic       wr_en_q;
    bin_addr_t  wr_addr_q;
    bin_count_t wr_data_q;

    // bins run 0..BIN_DEPTH-1 then wrap
    function automatic bin_addr_t next_addr(input bin_addr_t a);
        return (a == LAST_ADDR) ? '0 : a + 1'b1;
    endfunction

    bin_store #(
        .BIN_DEPTH(BIN_DEPTH)
    ) u_store (
        .clk      (clk),
        .rd_en_i  (vld_q[0]),
        .rd_addr_i(rd_addr_q),
        .wr_en_i  (wr_en_q),
        .wr_addr_i(wr_addr_q),
        .wr_data_i(wr_data_q),
        .rd_data_o(rd_data)     // two cycles after rd_en
    );

    assign stored = ctrl_i.zero_read ? '0 : rd_data;   // store not filled yet
    assign sum    = stored + bin_count_t'(cnt_q[2]);

    always_ff @(posedge clk) begin
        cnt_q[0] <= bin_i.count;
        cnt_q[1] <= cnt_q[0];
        cnt_q[2] <= cnt_q[1];

        // beat stage, 4 cycles after the input
        beat_q.last  <= (out_addr_q == LAST_ADDR);
        beat_q.addr  <= out_addr_q;
        beat_q.count <= sum;

        // write-back one stage behind the beat
        wr_addr_q <= beat_q.addr;
        wr_data_q <= ctrl_i.zero_write ? '0 : beat_q.count;

        if (hist_reset) begin
            vld_q        <= '0;
            rd_addr_q    <= '0;
            out_addr_q   <= '0;
            beat_q.valid <= 1'b0;
            wr_en_q      <= 1'b0;
        end else begin
            vld_q        <= {vld_q[1:0], bin_i.valid};
            beat_q.valid <= vld_q[2];
            wr_en_q      <= beat_q.valid;
            if (vld_q[0]) begin
                rd_addr_q <= next_addr(rd_addr_q);
            end
            if (vld_q[2]) begin
                out_addr_q <= next_addr(out_addr_q);
            end
        end
    end

    assign beat_o = beat_q;

endmodule

`default_nettype wire

// File: hw/peak_finder.sv
`default_nettype none

module peak_finder (
    input  wire                            clk,
    input  wire                            hist_reset,
    input  wire hist_accum_pkg::bin_beat_t beat_i,
    output hist_accum_pkg::bin_addr_t      index_max_o
);
    import hist_accum_pkg::*;

    bin_count_t max_q;        // largest total so far this frame
    bin_addr_t  max_addr_q;
    logic       take;
    bin_addr_t  cand_addr;

    assign take      = beat_i.count >= max_q;   // ties go to the later bin
    assign cand_addr = take ? beat_i.addr : max_addr_q;

    always_ff @(posedge clk) begin
        if (beat_i.valid && take) begin
            max_addr_q <= beat_i.addr;
        end

        if (hist_reset) begin
            max_q       <= '0;
            index_max_o <= '0;
        end else if (beat_i.valid) begin
            if (beat_i.last) begin
                max_q       <= '0;           // first beat of next frame always wins
                index_max_o <= cand_addr;    // held until the next frame ends
            end else if (take) begin
                max_q <= beat_i.count;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mean_calc.sv
`default_nettype none

module mean_calc (
    input  wire                            clk,
    input  wire                            hist_reset,
    input  wire hist_accum_pkg::bin_beat_t beat_i,
    output logic                           stats_valid_o,
    output hist_accum_pkg::bin_addr_t      offset_o
);
    import hist_accum_pkg::*;

    bin_index_t    n;              // one-based weight
    weighted_sum_t prod_q;         // n*x
    bin_count_t    x_q;            // x, aligned with the product
    logic          p_vld_q;
    logic          p_last_q;
    count_sum_t    sx_acc;
    count_sum_t    sx_next;
    count_sum_t    sx_lat;         // divisor for the whole division
    weighted_sum_t nx_acc;
    weighted_sum_t nx_next;
    weighted_sum_t nx_lat;
    logic          div_start_q;
    weighted_sum_t quo;
    count_sum_t    rem;
    logic          div_done;
    logic          round_up;
    bin_index_t    mean_n;         // rounded mean, still one-based

    assign n       = bin_index_t'(beat_i.addr) + 1'b1;
    assign sx_next = sx_acc + count_sum_t'(x_q);
    assign nx_next = nx_acc + prod_q;

    always_ff @(posedge clk) begin
        prod_q <= n * beat_i.count;
        x_q    <= beat_i.count;

        // final sums, stable while the divider runs
        if (p_vld_q && p_last_q) begin
            sx_lat <= sx_next;
            nx_lat <= nx_next;
        end

        if (hist_reset) begin
            p_vld_q       <= 1'b0;
            p_last_q      <= 1'b0;
            sx_acc        <= '0;
            nx_acc        <= '0;
            div_start_q   <= 1'b0;
            stats_valid_o <= 1'b0;
            offset_o      <= '0;
        end else begin
            p_vld_q       <= beat_i.valid;
            p_last_q      <= beat_i.valid && beat_i.last;
            div_start_q   <= p_vld_q && p_last_q;   // 2 cycles after last beat
            stats_valid_o <= div_done;
            if (p_vld_q) begin
                sx_acc <= p_last_q ? '0 : sx_next;   // zeroed for next frame
                nx_acc <= p_last_q ? '0 : nx_next;
            end
            if (div_done) begin
                // empty histogram has no mean, report bin 0
                offset_o <= (sx_lat == '0) ? '0 : bin_addr_t'(mean_n - 1'b1);
            end
        end
    end

    seq_divider u_div (
        .clk        (clk),
        .hist_reset (hist_reset),
        .start_i    (div_start_q),
        .dividend_i (nx_lat),
        .divisor_i  (sx_lat),
        .quotient_o (quo),
        .remainder_o(rem),
        .done_o     (div_done)
    );

    // round up once the remainder reaches half the divisor
    assign round_up = rem >= (sx_lat >> 1);
    assign mean_n   = bin_index_t'(quo) + bin_index_t'(round_up);

endmodule

`default_nettype wire

// File: hw/hist_accum_top.sv
`default_nettype none

module hist_accum_top #(
    parameter int BIN_DEPTH = 4096     // power of two, at most 4096
) (
    input  wire                          clk,
    input  wire                          hist_reset,
    input  wire hist_accum_pkg::bin_in_t bin_i,
    input  wire                          clear_i,     // one-cycle strobe
    output hist_accum_pkg::bin_beat_t    bin_o,
    output logic                         stats_valid_o,
    output hist_accum_pkg::bin_addr_t    index_max_o,
    output hist_accum_pkg::bin_addr_t    offset_o
);
    import hist_accum_pkg::*;

    bin_beat_t   beat;   // updated totals, fans out to all consumers
    store_ctrl_t ctrl;

    assign bin_o = beat;

    // clear and store-empty flags
    hist_ctrl #(
        .BIN_DEPTH(BIN_DEPTH)
    ) u_ctrl (
        .clk       (clk),
        .hist_reset(hist_reset),
        .clear_i   (clear_i),
        .beat_i    (beat),
        .ctrl_o    (ctrl)
    );

    // read, add, write back
    bin_updater #(
        .BIN_DEPTH(BIN_DEPTH)
    ) u_updater (
        .clk       (clk),
        .hist_reset(hist_reset),
        .bin_i     (bin_i),
        .ctrl_i    (ctrl),
        .beat_o    (beat)
    );

    peak_finder u_peak (
        .clk        (clk),
        .hist_reset (hist_reset),
        .beat_i     (beat),
        .index_max_o(index_max_o)
    );

    // weighted mean, also owns the stats strobe
    mean_calc u_mean (
        .clk          (clk),
        .hist_reset   (hist_reset),
        .beat_i       (beat),
        .stats_valid_o(stats_valid_o),
        .offset_o     (offset_o)
    );

endmodule

`default_nettype wire

// File: bench/hist_accum_tb.sv
`default_nettype none

module hist_accum_tb;
    import hist_accum_pkg::*;

    localparam int BINS    = 16;
    localparam int N_ROWS  = 10;
    localparam int TIMEOUT = N_ROWS * (BINS + 120) + 200;   // cycles
    localparam logic [31:0] SEED = 32'h3a3f;

    typedef enum logic [1:0] {PAT_RANDOM, PAT_ZERO, PAT_SINGLE, PAT_TIED} pattern_t;

    // one row per frame
    typedef struct packed {
        pattern_t   kind;
        logic [7:0] seed_off;       // added to the xorshift seed
        logic       clear_before;   // strobe clear_i ahead of the frame
    } row_t;

    logic        clk;
    logic        hist_reset = 1'b1;
    bin_in_t     bin_i      = '0;
    logic        clear_i    = 1'b0;
    bin_beat_t   bin_o;
    logic        stats_valid_o;
    bin_addr_t   index_max_o;
    bin_addr_t   offset_o;

    row_t        stim [N_ROWS];
    hist_word_t  counts [BINS];     // counts of the frame being driven
    bin_count_t  totals [BINS];     // expected sums of that frame
    bin_count_t  model [BINS];      // store content between frames
    bin_beat_t   exp_q [$];         // beats waiting for bin_o
    bin_beat_t   seen_exp;
    logic [3:0]  vhist = '0;        // sampled bin_i.valid, 4 edges deep
    int          stats_count  = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycles       = 0;

    hist_accum_top #(
        .BIN_DEPTH(BINS)
    ) uut (
        .clk          (clk),
        .hist_reset   (hist_reset),
        .bin_i        (bin_i),
        .clear_i      (clear_i),
        .bin_o        (bin_o),
        .stats_valid_o(stats_valid_o),
        .index_max_o  (index_max_o),
        .offset_o     (offset_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic row_t make_row(input pattern_t kind, input int off, input logic clr);
        row_t r;
        r.kind         = kind;
        r.seed_off     = off[7:0];
        r.clear_before = clr;
        return r;
    endfunction

    // last bin among equal maxima wins
    function automatic bin_addr_t expected_peak();
        bin_count_t best;
        bin_addr_t  idx;
        best = '0;
        idx  = '0;
        for (int i = 0; i < BINS; i++) begin
            if (totals[i] >= best) begin
                best = totals[i];
                idx  = bin_addr_t'(i);
            end
        end
        return idx;
    endfunction

    // round(sum n*x / sum x) - 1, n one-based
    function automatic bin_addr_t expected_offset();
        logic [63:0] sx;
        logic [63:0] nx;
        logic [63:0] q;
        logic [63:0] r;
        sx = '0;
        nx = '0;
        for (int i = 0; i < BINS; i++) begin
            sx = sx + totals[i];
            nx = nx + 64'(i + 1) * totals[i];
        end
        if (sx == 0) begin
            return '0;   // empty frame
        end
        q = nx / sx;
        r = nx % sx;
        if (r >= sx / 2) begin
            q = q + 1;   // half up, half floored
        end
        return bin_addr_t'(q - 1);
    endfunction

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        value_errors++;
        $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
    endtask

    task automatic drive_frame(input row_t row);
        logic [31:0] rnd;
        bin_count_t  peak;
        int          p1;
        int          p2;
        bin_beat_t   b;
        rnd  = xorshift(SEED + 32'(row.seed_off));
        peak = '0;
        for (int i = 0; i < BINS; i++) begin
            if (model[i] > peak) peak = model[i];
        end
        peak = peak + 100;                      // above every stored total
        p1   = int'(rnd % 32'(BINS));
        rnd  = xorshift(rnd);
        p2   = (p1 + 1 + int'(rnd % 32'(BINS - 1))) % BINS;   // never p1
        for (int i = 0; i < BINS; i++) begin
            rnd = xorshift(rnd);
            case (row.kind)
                PAT_RANDOM: counts[i] = rnd & 32'hff;   // small counts
                PAT_ZERO:   counts[i] = '0;
                default: begin
                    if (i == p1 || (row.kind == PAT_TIED && i == p2)) begin
                        counts[i] = hist_word_t'(peak - model[i]);   // total hits peak
                    end else begin
                        counts[i] = '0;
                    end
                end
            endcase
            totals[i] = model[i] + counts[i];
        end

        if (row.clear_before) begin
            @(posedge clk);
            clear_i <= 1'b1;
            @(posedge clk);
            clear_i <= 1'b0;
        end
        for (int i = 0; i < BINS; i++) begin
            @(posedge clk);
            bin_i.valid <= 1'b1;
            bin_i.count <= counts[i];
            b.valid = 1'b1;
            b.last  = (i == BINS - 1);
            b.addr  = bin_addr_t'(i);
            b.count = totals[i];
            exp_q.push_back(b);
        end
        @(posedge clk);
        bin_i.valid <= 1'b0;
        bin_i.count <= '0;

        // a cleared frame leaves zeros behind
        for (int i = 0; i < BINS; i++) begin
            model[i] = row.clear_before ? '0 : totals[i];
        end
    endtask

    task automatic check_stats(input int frame);
        bin_addr_t exp_peak;
        bin_addr_t exp_off;
        exp_peak = expected_peak();
        exp_off  = expected_offset();
        @(posedge clk);
        while (stats_valid_o !== 1'b1) @(posedge clk);   // watchdog bounds this
        if (index_max_o !== exp_peak) report_value("index_max_o", index_max_o, exp_peak);
        if (offset_o !== exp_off) report_value("offset_o", offset_o, exp_off);
        repeat (3) @(posedge clk);
        if (stats_count != frame + 1) begin
            other_errors++;
            $display("frame %0d: %0d stats pulses seen so far, %0d expected",
                     frame, stats_count, frame + 1);
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("frame %0d: %0d beats never appeared on bin_o", frame, exp_q.size());
        end
    endtask

    // output monitor, all values sampled before the edge updates them
    always @(posedge clk) begin
        if (hist_reset) begin
            vhist <= '0;
        end else begin
            if (bin_o.valid !== vhist[3]) report_value("bin_o.valid", bin_o.valid, vhist[3]);
            if (bin_o.valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("beat on bin_o at %0t with no input behind it", $time);
                end else begin
                    seen_exp = exp_q.pop_front();
                    if (bin_o.addr !== seen_exp.addr)
                        report_value("bin_o.addr", bin_o.addr, seen_exp.addr);
                    if (bin_o.last !== seen_exp.last)
                        report_value("bin_o.last", bin_o.last, seen_exp.last);
                    if (bin_o.count !== seen_exp.count)
                        report_value("bin_o.count", bin_o.count, seen_exp.count);
                end
            end
            if (stats_valid_o === 1'b1) stats_count <= stats_count + 1;
            vhist <= {vhist[2:0], bin_i.valid};
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, the run did not complete", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        stim[0] = make_row(PAT_RANDOM, 0, 1'b0);   // fresh store, output = input
        stim[1] = make_row(PAT_RANDOM, 1, 1'b0);   // sum of two frames
        stim[2] = make_row(PAT_SINGLE, 2, 1'b1);   // sums out, zeros written back
        stim[3] = make_row(PAT_RANDOM, 3, 1'b0);   // own counts only
        stim[4] = make_row(PAT_TIED,   4, 1'b1);
        stim[5] = make_row(PAT_ZERO,   0, 1'b0);   // all-zero totals
        stim[6] = make_row(PAT_SINGLE, 5, 1'b0);
        stim[7] = make_row(PAT_TIED,   6, 1'b0);   // tie on accumulated totals
        stim[8] = make_row(PAT_ZERO,   0, 1'b1);
        stim[9] = make_row(PAT_RANDOM, 7, 1'b0);
        for (int i = 0; i < BINS; i++) begin
            model[i] = '0;   // store reads as empty after reset
        end

        repeat (2) @(posedge clk);
        hist_reset <= 1'b0;
        repeat (2) @(posedge clk);

        for (int r = 0; r < N_ROWS; r++) begin
            drive_frame(stim[r]);
            check_stats(r);
        end

        repeat (10) @(posedge clk);
        if (stats_count != N_ROWS) begin
            other_errors++;
            $display("%0d stats pulses in total, %0d expected", stats_count, N_ROWS);
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hist_accum.f
hw/hist_accum_pkg.sv
hw/seq_divider.sv
hw/bin_store.sv
hw/hist_ctrl.sv
hw/bin_updater.sv
hw/peak_finder.sv
hw/mean_calc.sv
hw/hist_accum_top.sv
bench/hist_accum_tb.sv
